/* common/bridge_macros.svh */
// Timing and sizing constants for the bridge, included by the blocks that need them
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// Clock cycles per UART bit (oversampling ratio)
`define BRIDGE_CLKS_PER_BIT 8

// Clock cycles per SPI clock half-period
`define BRIDGE_SPI_HALF 2

// Byte FIFO entries, power of two
`define BRIDGE_FIFO_DEPTH 4

`endif

/* common/bridge_pkg.sv */
// Shared byte and FSM state types for the UART-to-SPI bridge, imported by RTL and testbench
package bridge_pkg;

  // One data byte as received on UART and sent on SPI
  typedef logic [7:0] bridge_byte_t;

  // UART deframer states
  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_START = 2'd1,
    RX_DATA  = 2'd2,
    RX_STOP  = 2'd3
  } rx_state_e;

  // SPI host shifter states
  typedef enum logic [1:0] {
    SPI_IDLE  = 2'd0,
    SPI_SHIFT = 2'd1,
    SPI_END   = 2'd2
  } spi_state_e;

endpackage

/* common/byte_fifo_if.sv */
// Push/pop strobe bundle between the byte producer, the byte FIFO and the byte consumer
`timescale 1ns/100ps

interface byte_fifo_if import bridge_pkg::*; ();

  // Write side
  bridge_byte_t wdata;
  logic         push;
  logic         full;

  // Read side, rdata is the head entry (fall-through)
  bridge_byte_t rdata;
  logic         pop;
  logic         empty;

  modport wr (
    output wdata, push,
    input  full
  );

  modport rd (
    output pop,
    input  rdata, empty
  );

  modport buf_wr (
    input  wdata, push,
    output full
  );

  modport buf_rd (
    input  pop,
    output rdata, empty
  );

endinterface

/* hdl/uart_rx/uart_rx_deframer.sv */
// Oversampled 8N1 UART receiver that checks the stop bit and pushes good bytes into the FIFO
`timescale 1ns/100ps

`include "bridge_macros.svh"

module uart_rx_deframer import bridge_pkg::*; (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           rx_i,
  output logic           frame_err_o,
  byte_fifo_if.wr        fifo
);

  localparam int unsigned ClksPerBit = `BRIDGE_CLKS_PER_BIT;
  localparam int unsigned HalfBit    = ClksPerBit / 2;
  localparam int unsigned TickW      = $clog2(ClksPerBit);

  ////////////////////////////////////////////////////////////
  // Input synchronizer and start edge
  ////////////////////////////////////////////////////////////

  logic rx_meta_q;
  logic rx_sync_q;
  logic rx_prev_q;
  logic rx_fall;

  // Line idles high
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  assign rx_fall = rx_prev_q && !rx_sync_q;

  ////////////////////////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////////////////////////

  rx_state_e        state_q;
  logic [TickW-1:0] tick_q;
  logic [2:0]       bit_q;
  logic             tick_last;
  logic             push_q;
  logic             ferr_q;
  bridge_byte_t     shift_q;

  assign tick_last = (tick_q == TickW'(ClksPerBit - 1));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= RX_IDLE;
      tick_q  <= '0;
      bit_q   <= '0;
      push_q  <= 1'b0;
      ferr_q  <= 1'b0;
    end else begin
      push_q <= 1'b0;
      ferr_q <= 1'b0;
      unique case (state_q)
        RX_IDLE: begin
          tick_q <= '0;
          bit_q  <= '0;
          if (rx_fall) begin
            state_q <= RX_START;
          end
        end
        // Recheck at half a bit so a short glitch is not taken as a start
        RX_START: begin
          if (tick_q == TickW'(HalfBit - 1)) begin
            tick_q  <= '0;
            state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
          end else begin
            tick_q <= tick_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (tick_last) begin
            tick_q <= '0;
            bit_q  <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            tick_q <= tick_q + 1'b1;
          end
        end
        // Mid stop bit decides push or framing error
        RX_STOP: begin
          if (tick_last) begin
            tick_q  <= '0;
            push_q  <= rx_sync_q;
            ferr_q  <= !rx_sync_q;
            state_q <= RX_IDLE;
          end else begin
            tick_q <= tick_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB first, so new bits enter at the top
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && tick_last) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign fifo.wdata  = shift_q;
  assign fifo.push   = push_q;
  assign frame_err_o = ferr_q;

endmodule

/* hdl/byte_fifo.sv */
// Synchronous fall-through FIFO between the UART deframer and the SPI shifter
`timescale 1ns/100ps

module byte_fifo import bridge_pkg::*; #(
  parameter type         payload_t = bridge_byte_t,
  parameter int unsigned Depth     = 4
) (
  input  logic         clk_i,
  input  logic         arst_n_i,
  byte_fifo_if.buf_wr  wr,
  byte_fifo_if.buf_rd  rd,
  output logic         overflow_o
);

  localparam int unsigned PtrW = $clog2(Depth);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wptr_q;
  logic [PtrW-1:0] rptr_q;
  logic [PtrW:0]   count_q;
  logic            do_push;
  logic            do_pop;

  ////////////////////////////////////////////////////////////
  // Levels and strobes
  ////////////////////////////////////////////////////////////

  assign wr.full  = (count_q == (PtrW + 1)'(Depth));
  assign rd.empty = (count_q == '0);
  assign rd.rdata = mem_q[rptr_q];

  assign do_push = wr.push && !wr.full;
  assign do_pop  = rd.pop && !rd.empty;

  // Dropped byte, flagged in the push cycle
  assign overflow_o = wr.push && wr.full;

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= wr.wdata;
    end
  end

endmodule

/* hdl/spi_host/spi_host_shifter.sv */
// SPI mode-0 host that pops bytes from the FIFO and shifts them out MSB first, stalled by hold
`timescale 1ns/100ps

`include "bridge_macros.svh"

module spi_host_shifter import bridge_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    hold_i,
  byte_fifo_if.rd fifo,
  output logic    spih_sck_o,
  output logic    spih_csb_o,
  output logic    spih_sd_o,
  output logic    spih_oe_o
);

  localparam int unsigned HalfCycles = `BRIDGE_SPI_HALF;
  localparam int unsigned DivW       = $clog2(2 * HalfCycles);

  spi_state_e      state_q;
  logic [DivW-1:0] div_q;
  logic [2:0]      bit_q;
  logic            sck_q;
  logic            csb_q;
  logic            oe_q;
  bridge_byte_t    shift_q;
  logic            pop;
  logic            half_done;
  logic            period_done;
  logic            sck_fall;

  ////////////////////////////////////////////////////////////
  // Start condition and clock divider
  ////////////////////////////////////////////////////////////

  // Hold is only looked at between bytes
  assign pop = (state_q == SPI_IDLE) && !fifo.empty && !hold_i;
  assign fifo.pop = pop;

  assign half_done   = (div_q == DivW'(HalfCycles - 1));
  assign period_done = (div_q == DivW'(2 * HalfCycles - 1));
  assign sck_fall    = (state_q == SPI_SHIFT) && half_done && sck_q;

  ////////////////////////////////////////////////////////////
  // Transfer FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= SPI_IDLE;
      div_q   <= '0;
      bit_q   <= '0;
      sck_q   <= 1'b0;
      csb_q   <= 1'b1;
      oe_q    <= 1'b0;
    end else begin
      unique case (state_q)
        SPI_IDLE: begin
          div_q <= '0;
          bit_q <= '0;
          if (pop) begin
            csb_q   <= 1'b0;
            oe_q    <= 1'b1;
            state_q <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          if (half_done) begin
            div_q <= '0;
            sck_q <= !sck_q;
            // Falling edge ends a bit
            if (sck_q) begin
              bit_q <= bit_q + 1'b1;
              if (bit_q == 3'd7) begin
                csb_q   <= 1'b1;
                oe_q    <= 1'b0;
                state_q <= SPI_END;
              end
            end
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        // Chip select stays high for one full SPI period
        SPI_END: begin
          if (period_done) begin
            div_q   <= '0;
            state_q <= SPI_IDLE;
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  // MSB sits on sd before the first rising edge, next bit after each fall
  always_ff @(posedge clk_i) begin
    if (pop) begin
      shift_q <= fifo.rdata;
    end else if (sck_fall) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  assign spih_sck_o = sck_q;
  assign spih_csb_o = csb_q;
  assign spih_oe_o  = oe_q;
  assign spih_sd_o  = oe_q & shift_q[7];

endmodule

/* hdl/uart_spi_bridge.sv */
// RTL top of the UART-to-SPI bridge, connecting deframer, byte FIFO and SPI shifter
`timescale 1ns/100ps

`include "bridge_macros.svh"

module uart_spi_bridge import bridge_pkg::*; (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic uart_rx_i,
  input  logic hold_i,
  output logic spih_sck_o,
  output logic spih_csb_o,
  output logic spih_sd_o,
  output logic spih_oe_o,
  output logic frame_err_o,
  output logic overflow_o
);

  byte_fifo_if u_fifo_if ();

  ////////////////////////////////////////////////////////////
  // UART receive side
  ////////////////////////////////////////////////////////////

  uart_rx_deframer u_uart_rx_deframer (
    .clk_i       ( clk_i         ),
    .arst_n_i    ( arst_n_i      ),
    .rx_i        ( uart_rx_i     ),
    .frame_err_o ( frame_err_o   ),
    .fifo        ( u_fifo_if.wr  )
  );

  ////////////////////////////////////////////////////////////
  // Byte buffer
  ////////////////////////////////////////////////////////////

  byte_fifo #(
    .payload_t ( bridge_byte_t      ),
    .Depth     ( `BRIDGE_FIFO_DEPTH )
  ) u_byte_fifo (
    .clk_i      ( clk_i            ),
    .arst_n_i   ( arst_n_i         ),
    .wr         ( u_fifo_if.buf_wr ),
    .rd         ( u_fifo_if.buf_rd ),
    .overflow_o ( overflow_o       )
  );

  ////////////////////////////////////////////////////////////
  // SPI host side
  ////////////////////////////////////////////////////////////

  spi_host_shifter u_spi_host_shifter (
    .clk_i      ( clk_i        ),
    .arst_n_i   ( arst_n_i     ),
    .hold_i     ( hold_i       ),
    .fifo       ( u_fifo_if.rd ),
    .spih_sck_o ( spih_sck_o   ),
    .spih_csb_o ( spih_csb_o   ),
    .spih_sd_o  ( spih_sd_o    ),
    .spih_oe_o  ( spih_oe_o    )
  );

endmodule

/* verification/uart_spi_bridge_props.sv */
// Protocol assertions on the SPI pins and status pulses, bound into the bridge top
`timescale 1ns/100ps

`include "bridge_macros.svh"

module uart_spi_bridge_props (
  input logic clk_i,
  input logic arst_n_i,
  input logic sck_i,
  input logic csb_i,
  input logic sd_i,
  input logic oe_i,
  input logic frame_err_i,
  input logic overflow_i
);

  localparam int unsigned HalfCycles = `BRIDGE_SPI_HALF;

  // Pins are only driven inside a chip-select window
  csb_low_has_oe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !csb_i |-> oe_i) else $error("chip select low while output enable is low");

  sck_idle_low: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    csb_i |-> !sck_i) else $error("SPI clock high outside a chip-select window");

  status_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(overflow_i && frame_err_i)) else $error("overflow and framing error in one cycle");

  // Mode 0 data may only move while sck is low
  sd_stable_high: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (sck_i && $past(sck_i)) |-> $stable(sd_i)) else $error("SPI data changed while sck high");

  sck_high_width: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(sck_i) |-> ##HalfCycles !sck_i) else $error("SPI clock high phase has wrong width");

endmodule

bind uart_spi_bridge uart_spi_bridge_props u_uart_spi_bridge_props (
  .clk_i       ( clk_i       ),
  .arst_n_i    ( arst_n_i    ),
  .sck_i       ( spih_sck_o  ),
  .csb_i       ( spih_csb_o  ),
  .sd_i        ( spih_sd_o   ),
  .oe_i        ( spih_oe_o   ),
  .frame_err_i ( frame_err_o ),
  .overflow_i  ( overflow_o  )
);

/* verification/tb_uart_spi_bridge.sv */
// Fixture testbench run as top that drives UART frames and hold and models the SPI device
`timescale 1ns/100ps

`include "bridge_macros.svh"

module tb_uart_spi_bridge import bridge_pkg::*; ();

  localparam int BitCycles   = `BRIDGE_CLKS_PER_BIT;
  localparam int Depth       = `BRIDGE_FIFO_DEPTH;
  localparam int NumRows     = 19;
  localparam int DrainCycles = (Depth + 1) * 24 * `BRIDGE_SPI_HALF;
  localparam int WatchCycles = NumRows * 12 * BitCycles + 8 * DrainCycles;
  localparam logic [1:0] HoldLow  = 2'd0;
  localparam logic [1:0] HoldHigh = 2'd1;
  localparam logic [1:0] HoldMid  = 2'd2;

  logic clk_i;
  logic arst_n_i;
  logic uart_rx_i;
  logic hold_i;
  logic spih_sck_o;
  logic spih_csb_o;
  logic spih_sd_o;
  logic spih_oe_o;
  logic frame_err_o;
  logic overflow_o;

  // Stimulus table
  string        row_name [NumRows];
  bridge_byte_t row_data [NumRows];
  bit           row_stop_ok [NumRows];
  logic [1:0]   row_hold [NumRows];
  int           row_cnt = 0;

  logic [31:0]  lfsr_q = 32'ha152;
  bridge_byte_t rx_bytes [$];
  bridge_byte_t exp_bytes [$];
  string        exp_names [$];
  int ferr_cnt = 0;
  int ovf_cnt = 0;
  int exp_ferr = 0;
  int exp_ovf = 0;
  int model_count = 0;
  int checked = 0;
  int value_errs = 0;
  int proto_errs = 0;

  uart_spi_bridge u_uart_spi_bridge (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic bridge_byte_t rand_byte();
    bridge_byte_t b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      b = {b[6:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return b;
  endfunction

  task automatic add_row(input string name, input bridge_byte_t data, input bit stop_ok,
                         input logic [1:0] hold);
    row_name[row_cnt] = name;
    row_data[row_cnt] = data;
    row_stop_ok[row_cnt] = stop_ok;
    row_hold[row_cnt] = hold;
    row_cnt++;
  endtask

  task automatic report_mismatch(input string name, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("FAIL %s %s: expected 0x%0h, actual 0x%0h", name, what, exp, act);
    value_errs++;
  endtask

  // 8N1 frame sent LSB first and followed by one idle bit
  task automatic send_frame(input bridge_byte_t data, input bit stop_ok);
    uart_rx_i = 1'b0;
    repeat (BitCycles) @(negedge clk_i);
    for (int i = 0; i < 8; i++) begin
      uart_rx_i = data[i];
      repeat (BitCycles) @(negedge clk_i);
    end
    uart_rx_i = stop_ok;
    repeat (BitCycles) @(negedge clk_i);
    uart_rx_i = 1'b1;
    repeat (BitCycles) @(negedge clk_i);
  endtask

  // Wait until every expected byte came out on SPI, then compare in order
  task automatic wait_drain(input string name);
    int cycles;
    cycles = 0;
    while (rx_bytes.size() < exp_bytes.size() && cycles < DrainCycles) begin
      @(negedge clk_i);
      cycles++;
    end
    if (rx_bytes.size() < exp_bytes.size()) begin
      $display("%s: buffered bytes did not come out on SPI in time", name);
      proto_errs++;
    end
    while (checked < rx_bytes.size()) begin
      if (checked >= exp_bytes.size()) begin
        $display("%s: SPI carried unexpected byte 0x%02h", name, rx_bytes[checked]);
        proto_errs++;
      end else if (rx_bytes[checked] !== exp_bytes[checked]) begin
        report_mismatch(exp_names[checked], "SPI byte", exp_bytes[checked], rx_bytes[checked]);
      end
      checked++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // SPI device model and status pulse counters
  ////////////////////////////////////////////////////////////

  logic         sck_last = 1'b0;
  logic         csb_last = 1'b1;
  logic         hold_last = 1'b0;
  int           spi_bits = 0;
  bridge_byte_t spi_byte = '0;

  always @(posedge clk_i) begin
    if (arst_n_i) begin
      if (frame_err_o) ferr_cnt++;
      if (overflow_o) ovf_cnt++;
      if (csb_last && !spih_csb_o && hold_last) begin
        $display("SPI transfer started while hold was high");
        proto_errs++;
      end
      // MSB first on each sck rise
      if (!spih_csb_o && spih_sck_o && !sck_last) begin
        spi_byte = {spi_byte[6:0], spih_sd_o};
        spi_bits++;
      end
      if (!csb_last && spih_csb_o) begin
        if (spi_bits != 8) begin
          $display("Chip-select window carried %0d bits instead of 8", spi_bits);
          proto_errs++;
        end
        rx_bytes.push_back(spi_byte);
        spi_bits = 0;
      end
    end
    sck_last = spih_sck_o;
    csb_last = spih_csb_o;
    hold_last = hold_i;
  end

  initial begin
    repeat (WatchCycles) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d clock cycles", WatchCycles);
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    arst_n_i = 1'b0;
    uart_rx_i = 1'b1;
    hold_i = 1'b0;
    add_row("fixed_a5", 8'hA5, 1'b1, HoldLow);
    add_row("fixed_3c", 8'h3C, 1'b1, HoldLow);
    add_row("fixed_01", 8'h01, 1'b1, HoldLow);
    add_row("fixed_80", 8'h80, 1'b1, HoldLow);
    add_row("rand_0", rand_byte(), 1'b1, HoldLow);
    add_row("rand_1", rand_byte(), 1'b1, HoldLow);
    add_row("ferr_7e", 8'h7E, 1'b0, HoldLow);
    add_row("after_ferr", 8'hC3, 1'b1, HoldLow);
    add_row("ferr_ff", 8'hFF, 1'b0, HoldLow);
    add_row("hold_0", 8'h11, 1'b1, HoldHigh);
    add_row("hold_1", rand_byte(), 1'b1, HoldHigh);
    add_row("hold_2", 8'h33, 1'b1, HoldHigh);
    add_row("hold_3", 8'h44, 1'b1, HoldHigh);
    add_row("hold_ovf_0", 8'h55, 1'b1, HoldHigh);
    add_row("hold_ovf_1", 8'h66, 1'b1, HoldHigh);
    add_row("release", 8'h5A, 1'b1, HoldLow);
    add_row("mid_xfer", 8'h96, 1'b1, HoldMid);
    add_row("mid_wait", 8'h69, 1'b1, HoldHigh);
    add_row("mid_release", 8'hE7, 1'b1, HoldLow);
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    repeat (4) @(negedge clk_i);
    if ({spih_csb_o, spih_sck_o, spih_sd_o, spih_oe_o} !== 4'b1000) begin
      report_mismatch("reset", "csb/sck/sd/oe", 4'b1000,
                      {spih_csb_o, spih_sck_o, spih_sd_o, spih_oe_o});
    end
    if (ferr_cnt != 0 || ovf_cnt != 0) begin
      $display("Status pulse seen right after reset");
      proto_errs++;
    end
    for (int r = 0; r < NumRows; r++) begin
      if (row_hold[r] == HoldHigh) begin
        hold_i = 1'b1;
      end else if (hold_i) begin
        hold_i = 1'b0;
        wait_drain(row_name[r]);
        model_count = 0;
      end
      send_frame(row_data[r], row_stop_ok[r]);
      // Good bytes are dropped once the expected FIFO occupancy reaches the depth
      if (!row_stop_ok[r]) begin
        exp_ferr++;
      end else if (model_count == Depth) begin
        exp_ovf++;
      end else begin
        exp_bytes.push_back(row_data[r]);
        exp_names.push_back(row_name[r]);
        model_count++;
      end
      if (row_hold[r] == HoldMid) begin
        for (int c = 0; c < DrainCycles && spih_csb_o; c++) @(negedge clk_i);
        if (spih_csb_o) begin
          $display("%s: no SPI transfer in progress to hold against", row_name[r]);
          proto_errs++;
        end
        hold_i = 1'b1;
      end
      // Byte in flight must finish even under hold
      if (!hold_i || row_hold[r] == HoldMid) begin
        wait_drain(row_name[r]);
        model_count = 0;
      end
      if (ferr_cnt != exp_ferr) begin
        report_mismatch(row_name[r], "frame_err pulses", exp_ferr, ferr_cnt);
      end
      if (ovf_cnt != exp_ovf) begin
        report_mismatch(row_name[r], "overflow pulses", exp_ovf, ovf_cnt);
      end
    end
    // Long enough for a stray trailing transfer to finish
    repeat (DrainCycles) @(negedge clk_i);
    if (rx_bytes.size() != exp_bytes.size()) begin
      report_mismatch("final", "SPI byte count", exp_bytes.size(), rx_bytes.size());
    end
    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* uart_spi_bridge.f */
+incdir+common
common/bridge_pkg.sv
common/byte_fifo_if.sv
hdl/uart_rx/uart_rx_deframer.sv
hdl/byte_fifo.sv
hdl/spi_host/spi_host_shifter.sv
hdl/uart_spi_bridge.sv
verification/uart_spi_bridge_props.sv
verification/tb_uart_spi_bridge.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_uart_spi_bridge
FILELIST  ?= uart_spi_bridge.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
